// ==== src.f ====
hdl/riscv_pkg.sv
hdl/alu_pkg.sv
hdl/shift_if.sv
hdl/alu_decoder.sv
hdl/serial_shifter.sv
hdl/alu.sv
hdl/execute_top.sv
sim/alu_asserts.sv
sim/tb_execute.sv

// ==== Makefile ====
# Verilator build and run of the execute stage testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_execute -f src.f -o sim_execute
	./obj_dir/sim_execute | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_execute.sv ====
// Directed testbench for the execute stage with a reference model and latency checks.
`default_nettype none

module tb_execute;
    timeunit 1ns;
    timeprecision 100ps;

    import riscv_pkg::*;

    localparam int TIMEOUT = 40;                        // cycles allowed for ready.

    logic    clk;
    logic    resetn;
    logic    valid;
    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_b5;
    word_t   a;
    word_t   b;
    word_t   result;
    logic    zero;
    logic    ready;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    execute_top #(.serial_shift(1'b1)) UUT (
        .clk(clk), .resetn(resetn), .valid(valid), .opcode(opcode), .funct3(funct3),
        .funct7_b5(funct7_b5), .a(a), .b(b), .result(result), .zero(zero), .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // RV32I result of one instruction on the two operands.
    function automatic word_t model_result(opcode_t op, funct3_t f3, logic f7, word_t x,
                                           word_t y);
        logic [4:0] s;
        s = y[4:0];
        case (op)
            LUI: return y;
            BRANCH: begin
                case (f3)
                    F3_BEQ:  return word_t'(x == y);
                    F3_BNE:  return word_t'(x != y);
                    F3_BLT:  return word_t'($signed(x) < $signed(y));
                    F3_BGE:  return word_t'($signed(x) >= $signed(y));
                    F3_BLTU: return word_t'(x < y);
                    F3_BGEU: return word_t'(x >= y);
                    default: return x + y;
                endcase
            end
            OP, OP_IMM: begin
                case (f3)
                    F3_ADD_SUB: return (op == OP && f7) ? x - y : x + y;
                    F3_SLL:     return x << s;
                    F3_SLT:     return word_t'($signed(x) < $signed(y));
                    F3_SLTU:    return word_t'(x < y);
                    F3_XOR:     return x ^ y;
                    F3_SRL_SRA: return f7 ? word_t'($signed(x) >>> s) : x >> s;
                    F3_OR:      return x | y;
                    default:    return x & y;
                endcase
            end
            default: return x + y;                      // loads, stores and auipc add.
        endcase
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected flag %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("** Error %s: expected ready after %0d edges, actual %0d", name,
                     expected, actual);
        end
    endtask

    // Applies one instruction, waits for ready and checks result, zero and latency.
    task automatic apply_instr(input string name, input opcode_t op, input funct3_t f3,
                               input logic f7, input word_t x, input word_t y);
        word_t exp_res;
        int    edges;
        int    exp_edges;
        exp_res   = model_result(op, f3, f7, x, y);
        exp_edges = 0;
        if ((op == OP || op == OP_IMM) && (f3 == F3_SLL || f3 == F3_SRL_SRA)) begin
            exp_edges = (y[4:0] == 5'd0) ? 1 : int'(y[4:0]);
        end
        @(negedge clk);
        valid     = 1'b1;
        opcode    = op;
        funct3    = f3;
        funct7_b5 = f7;
        a         = x;
        b         = y;
        edges     = 0;
        #10;
        while (!ready && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            #10;                                        // sample away from the clock edge.
        end
        if (!ready) begin
            timeouts++;
            $display("%s: ready did not arrive within %0d cycles", name, TIMEOUT);
        end else begin
            check_word(name, exp_res, result);
            check_flag({name, " zero"}, exp_res == '0, zero);
            check_latency(name, exp_edges, edges);
        end
        @(negedge clk);
        valid = 1'b0;                                   // one idle cycle before the next request.
    endtask

    task automatic reset_behavior();
        opcode = OP;
        funct3 = F3_SLL;
        b      = 32'd3;
        valid  = 1'b1;                                  // a shift request held during reset.
        repeat (2) begin
            @(posedge clk);
            #10;
            check_flag("ready in reset", 1'b0, ready);
        end
        @(negedge clk);
        resetn = 1'b1;
        valid  = 1'b0;
        @(posedge clk);
        #10;
        check_flag("ready after reset", 1'b0, ready);
    endtask

    task automatic arith_logic();
        word_t x;
        word_t y;
        word_t imm;
        for (int i = 0; i < 20; i++) begin
            x   = $urandom();
            y   = $urandom();
            imm = {{20{y[11]}}, y[11:0]};
            apply_instr("add", OP, F3_ADD_SUB, 1'b0, x, y);
            apply_instr("sub", OP, F3_ADD_SUB, 1'b1, x, y);
            apply_instr("xor", OP, F3_XOR, 1'b0, x, y);
            apply_instr("or", OP, F3_OR, 1'b0, x, y);
            apply_instr("and", OP, F3_AND, 1'b0, x, y);
            apply_instr("addi", OP_IMM, F3_ADD_SUB, imm[10], x, imm);
            apply_instr("xori", OP_IMM, F3_XOR, imm[10], x, imm);
            apply_instr("ori", OP_IMM, F3_OR, imm[10], x, imm);
            apply_instr("andi", OP_IMM, F3_AND, imm[10], x, imm);
        end
        apply_instr("sub equal", OP, F3_ADD_SUB, 1'b1, x, x);
        apply_instr("and disjoint", OP, F3_AND, 1'b0, x, ~x);
    endtask

    task automatic set_less_than();
        word_t lhs [4] = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000, 32'hffff_ffff};
        word_t rhs [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0000};
        word_t x;
        word_t y;
        for (int i = 0; i < 8; i++) begin
            x = $urandom();
            y = $urandom();
            if (i < 4) begin                            // sign boundaries first.
                x = lhs[i[1:0]];
                y = rhs[i[1:0]];
            end
            apply_instr("slt", OP, F3_SLT, 1'b0, x, y);
            apply_instr("sltu", OP, F3_SLTU, 1'b0, x, y);
            apply_instr("slti", OP_IMM, F3_SLT, 1'b0, x, {{20{y[11]}}, y[11:0]});
            apply_instr("sltiu", OP_IMM, F3_SLTU, 1'b0, x, {{20{y[11]}}, y[11:0]});
        end
    endtask

    task automatic branch_compares();
        word_t   lhs [3] = '{32'd5, 32'hffff_fffd, 32'd1};   // equal, signed less, unsigned less.
        word_t   rhs [3] = '{32'd5, 32'd2, 32'h8000_0000};
        funct3_t f3s [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 6; k++) begin
                apply_instr($sformatf("branch f3 %0d pair %0d", f3s[k[2:0]], p), BRANCH,
                            f3s[k[2:0]], 1'b0, lhs[p[1:0]], rhs[p[1:0]]);
            end
        end
    endtask

    task automatic shift_ops();
        logic [4:0] amounts [4] = '{5'd0, 5'd1, 5'd17, 5'd31};
        word_t      x;
        word_t      y;
        foreach (amounts[i]) begin
            x = $urandom() | 32'h8000_0000;             // sign bit set shows the fill kind.
            y = {27'($urandom()), amounts[i]};
            apply_instr($sformatf("sll by %0d", amounts[i]), OP, F3_SLL, 1'b0, x, y);
            apply_instr($sformatf("srl by %0d", amounts[i]), OP, F3_SRL_SRA, 1'b0, x, y);
            apply_instr($sformatf("sra by %0d", amounts[i]), OP, F3_SRL_SRA, 1'b1, x, y);
            apply_instr($sformatf("srai by %0d", amounts[i]), OP_IMM, F3_SRL_SRA, 1'b1, ~x,
                        {27'd0, amounts[i]});
        end
    endtask

    task automatic upper_and_memory();
        word_t x;
        word_t y;
        x = $urandom();
        y = $urandom();
        apply_instr("lui", LUI, 3'd0, 1'b0, x, y & 32'hffff_f000);
        apply_instr("auipc", AUIPC, 3'd0, 1'b0, x, y & 32'hffff_f000);
        apply_instr("load", LOAD, 3'b010, 1'b0, x, {{20{y[11]}}, y[11:0]});
        apply_instr("store", STORE, 3'b010, 1'b0, x, {{20{y[23]}}, y[23:12]});
        apply_instr("unknown opcode", 7'b1111111, 3'b101, 1'b1, x, y);
    endtask

    task automatic back_to_back_shifts();
        word_t x;
        x = $urandom();
        apply_instr("first of two shifts", OP, F3_SLL, 1'b0, x, 32'd9);
        apply_instr("second of two shifts", OP, F3_SRL_SRA, 1'b1, ~x, 32'd4);
    endtask

    // Keeps valid up one cycle past ready, so the shifter sees start together with done.
    task automatic held_shift();
        word_t x;
        word_t exp_res;
        int    edges;
        x       = $urandom();
        exp_res = model_result(OP, F3_SLL, 1'b0, x, 32'd2);
        @(negedge clk);
        valid     = 1'b1;
        opcode    = OP;
        funct3    = F3_SLL;
        funct7_b5 = 1'b0;
        a         = x;
        b         = 32'd2;
        edges     = 0;
        #10;
        while (!ready && edges < TIMEOUT) begin
            @(posedge clk);
            edges++;
            #10;
        end
        if (!ready) begin
            timeouts++;
            $display("held shift: ready did not arrive within %0d cycles", TIMEOUT);
        end else begin
            @(posedge clk);                             // start is still high on this edge.
            #10;
            check_flag("held shift ready pulse", 1'b0, ready);
            check_word("held shift result", exp_res, result);
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    initial begin
        resetn    = 1'b0;
        valid     = 1'b0;
        opcode    = '0;
        funct3    = '0;
        funct7_b5 = 1'b0;
        a         = '0;
        b         = '0;
        void'($urandom(90));
        reset_behavior();
        arith_logic();
        set_less_than();
        branch_compares();
        shift_ops();
        upper_and_memory();
        back_to_back_shifts();
        held_shift();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/alu_asserts.sv ====
// Bound checks on the serial shifter handshake and on its reset behavior.
`default_nettype none

module alu_asserts (
    input wire                   clk,
    input wire                   resetn,
    input wire                   start,
    input wire                   done,
    input wire riscv_pkg::word_t result
);
    timeunit 1ns;
    timeprecision 100ps;

    // done stays low through reset and in the first cycle after it.
    done_in_reset: assert property (@(posedge clk) !resetn |=> !done)
        else $error("shifter done is high during reset or right after it");

    done_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
        else $error("shifter done lasted longer than one cycle");

    // the shifter ignores a start that is still held in the cycle after done.
    result_hold: assert property (@(posedge clk) disable iff (!resetn)
                                  (done && start) |=> $stable(result))
        else $error("shifter result changed while start was held after done");

endmodule

bind serial_shifter alu_asserts u_asserts (
    .clk    (clk),
    .resetn (resetn),
    .start  (sh.start),
    .done   (sh.done),
    .result (sh.result)
);

`default_nettype wire

// ==== hdl/execute_top.sv ====
// Execute stage top level joining the decoder, the ALU and the serial shifter.
`default_nettype none

module execute_top #(
    parameter bit serial_shift = 1'b1
) (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire                     valid,
    input  wire riscv_pkg::opcode_t opcode,
    input  wire riscv_pkg::funct3_t funct3,
    input  wire                     funct7_b5,
    input  wire riscv_pkg::word_t   a,
    input  wire riscv_pkg::word_t   b,
    output riscv_pkg::word_t        result,
    output logic                    zero,
    output logic                    ready
);
    import alu_pkg::*;

    alu_ctrl_t alucontrol;

    shift_if sh_bus ();

    alu_decoder u_decoder (
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7_b5  (funct7_b5),
        .alucontrol (alucontrol)
    );

    alu #(
        .serial_shift (serial_shift)
    ) u_alu (
        .clk        (clk),
        .resetn     (resetn),
        .a          (a),
        .b          (b),
        .alucontrol (alucontrol),
        .valid      (valid),
        .ready      (ready),
        .result     (result),
        .zero       (zero),
        .sh         (sh_bus.requester)
    );

    serial_shifter u_shifter (
        .clk    (clk),
        .resetn (resetn),
        .sh     (sh_bus.shifter)              // stays idle when the barrel path is built.
    );

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// RV32I ALU with a shared compare adder and a serial or barrel path for shifts.
`default_nettype none

module alu #(
    parameter bit serial_shift = 1'b1
) (
    input  wire                     clk,
    input  wire                     resetn,
    input  wire riscv_pkg::word_t   a,
    input  wire riscv_pkg::word_t   b,
    input  wire alu_pkg::alu_ctrl_t alucontrol,
    input  wire                     valid,
    output logic                    ready,
    output riscv_pkg::word_t        result,
    output logic                    zero,
    shift_if.requester              sh
);
    import riscv_pkg::*;
    import alu_pkg::*;

    logic        is_shift;
    logic        is_sub;
    word_t       condinv;
    logic [32:0] sum;
    logic        eq;
    logic        lt;
    logic        ltu;
    word_t       shift_result;
    logic        shift_ready;
    logic        shift_busy;                            // a serial request has been issued.

    assign is_shift = (alucontrol == ALU_SLL) || (alucontrol == ALU_SRL) ||
                      (alucontrol == ALU_SRA);

    // every compare subtracts, so one adder serves them all.
    assign is_sub = (alucontrol == ALU_SUB)  || (alucontrol == ALU_SLT)  ||
                    (alucontrol == ALU_SLTU) || (alucontrol == ALU_BEQ)  ||
                    (alucontrol == ALU_BNE)  || (alucontrol == ALU_BLT)  ||
                    (alucontrol == ALU_BGE)  || (alucontrol == ALU_BLTU) ||
                    (alucontrol == ALU_BGEU);

    assign condinv = is_sub ? ~b : b;
    assign sum     = {1'b0, a} + {1'b0, condinv} + {32'd0, is_sub};
    assign eq      = (sum[31:0] == '0);
    assign ltu     = ~sum[32];                          // no carry out means a borrow.
    assign lt      = (a[31] ^ b[31]) ? a[31] : ltu;     // equal signs reduce to the unsigned case.

    assign sh.operand = a;
    assign sh.amount  = b[4:0];
    assign sh.op      = (alucontrol == ALU_SRA) ? SH_SRA :
                        (alucontrol == ALU_SRL) ? SH_SRL : SH_SLL;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            shift_busy <= 1'b0;
        end else if (sh.done) begin
            shift_busy <= 1'b0;
        end else if (sh.start) begin
            shift_busy <= 1'b1;
        end
    end

    if (serial_shift) begin : g_serial
        assign sh.start     = valid & is_shift;         // held until the shifter answers.
        assign shift_result = sh.result;
        assign shift_ready  = sh.done & shift_busy;
    end else begin : g_barrel
        word_t sll_res;
        word_t srl_res;
        word_t sra_res;

        assign sll_res      = a << b[4:0];
        assign srl_res      = a >> b[4:0];
        assign sra_res      = word_t'($signed(a) >>> b[4:0]);
        assign sh.start     = 1'b0;
        assign shift_result = (sh.op == SH_SRA) ? sra_res :
                              (sh.op == SH_SRL) ? srl_res : sll_res;
        assign shift_ready  = valid;
    end

    assign ready = is_shift ? shift_ready : valid;

    always_comb begin
        case (alucontrol)
            ALU_ADD, ALU_SUB, ALU_AUIPC: result = sum[31:0];
            ALU_XOR:   result = a ^ b;
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_SLL, ALU_SRL, ALU_SRA: result = shift_result;
            ALU_SLT:   result = {31'd0, lt};
            ALU_SLTU:  result = {31'd0, ltu};
            ALU_LUI:   result = b;
            ALU_BEQ:   result = {31'd0, eq};
            ALU_BNE:   result = {31'd0, ~eq};
            ALU_BLT:   result = {31'd0, lt};
            ALU_BGE:   result = {31'd0, ~lt};
            ALU_BLTU:  result = {31'd0, ltu};
            ALU_BGEU:  result = {31'd0, ~ltu};
            default:   result = sum[31:0];
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== hdl/serial_shifter.sv ====
// Serial shifter that moves the operand one bit per clock and pulses done at the end.
`default_nettype none

module serial_shifter (
    input wire      clk,
    input wire      resetn,
    shift_if.shifter sh
);
    import riscv_pkg::*;
    import alu_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_SHIFT
    } state_t;

    state_t    state;
    shamt_t    count;                                   // shifts still to do after this one.
    word_t     data;
    shift_op_t op_q;
    logic      done_q;

    // One step of the selected shift kind.
    function automatic word_t shift_one(input word_t value, input shift_op_t kind);
        word_t next;
        case (kind)
            SH_SRA:  next = {value[31], value[31:1]};
            SH_SRL:  next = {1'b0, value[31:1]};
            default: next = {value[30:0], 1'b0};
        endcase
        return next;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= S_IDLE;
            count  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;                             // done lasts a single cycle.
            case (state)
                S_IDLE: begin
                    // the cycle that shows done ignores the start still held by the ALU.
                    if (sh.start && !done_q) begin
                        op_q <= sh.op;
                        if (sh.amount == '0) begin
                            data   <= sh.operand;
                            done_q <= 1'b1;
                        end else begin
                            data <= shift_one(sh.operand, sh.op);  // first step on the capture edge.
                            if (sh.amount == 5'd1) begin
                                done_q <= 1'b1;
                            end else begin
                                count <= sh.amount - 5'd1;
                                state <= S_SHIFT;
                            end
                        end
                    end
                end
                S_SHIFT: begin
                    data  <= shift_one(data, op_q);
                    count <= count - 5'd1;
                    if (count == 5'd1) begin
                        done_q <= 1'b1;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign sh.done   = done_q;
    assign sh.result = data;

endmodule

`default_nettype wire

// ==== hdl/alu_decoder.sv ====
// Combinational decoder from opcode, funct3 and funct7 bit 5 to the ALU operation.
`default_nettype none

module alu_decoder (
    input  wire riscv_pkg::opcode_t opcode,
    input  wire riscv_pkg::funct3_t funct3,
    input  wire                     funct7_b5,
    output alu_pkg::alu_ctrl_t      alucontrol
);
    import riscv_pkg::*;
    import alu_pkg::*;

    logic is_op;

    assign is_op = (opcode == OP);                      // only the register form knows SUB.

    always_comb begin
        alucontrol = ALU_ADD;                           // unknown opcodes fall back to add.
        case (opcode)
            LOAD, STORE: begin
                alucontrol = ALU_ADD;                   // address is base plus offset.
            end
            LUI: begin
                alucontrol = ALU_LUI;
            end
            AUIPC: begin
                alucontrol = ALU_AUIPC;
            end
            BRANCH: begin
                case (funct3)
                    F3_BEQ:  alucontrol = ALU_BEQ;
                    F3_BNE:  alucontrol = ALU_BNE;
                    F3_BLT:  alucontrol = ALU_BLT;
                    F3_BGE:  alucontrol = ALU_BGE;
                    F3_BLTU: alucontrol = ALU_BLTU;
                    F3_BGEU: alucontrol = ALU_BGEU;
                    default: alucontrol = ALU_ADD;     // funct3 010 and 011 are not branches.
                endcase
            end
            OP, OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        // an immediate add may have bit 30 set by a negative immediate.
                        alucontrol = (is_op && funct7_b5) ? ALU_SUB : ALU_ADD;
                    end
                    F3_SLL:  alucontrol = ALU_SLL;
                    F3_SLT:  alucontrol = ALU_SLT;
                    F3_SLTU: alucontrol = ALU_SLTU;
                    F3_XOR:  alucontrol = ALU_XOR;
                    F3_SRL_SRA: begin
                        alucontrol = funct7_b5 ? ALU_SRA : ALU_SRL;  // same bit in both forms.
                    end
                    F3_OR:   alucontrol = ALU_OR;
                    F3_AND:  alucontrol = ALU_AND;
                    default: alucontrol = ALU_ADD;
                endcase
            end
            default: begin
                alucontrol = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/shift_if.sv ====
// Shift request and result bundle between the ALU and the serial shifter.
`default_nettype none

interface shift_if;
    import riscv_pkg::*;
    import alu_pkg::*;

    logic      start;                                   // held by the ALU until done.
    shift_op_t op;
    word_t     operand;
    shamt_t    amount;
    logic      done;                                    // one-cycle pulse from the shifter.
    word_t     result;                                  // valid while done is high.

    modport requester (
        output start, op, operand, amount,
        input  done, result
    );

    modport shifter (
        input  start, op, operand, amount,
        output done, result
    );

endinterface

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
// ALU operation codes, shift kinds and the widths of the ALU control fields.
`default_nettype none

package alu_pkg;

    localparam int ALU_CTRL_W = 5;                      // enough room for all eighteen operations.
    localparam int SHAMT_W    = 5;                      // shifts on a 32-bit word need five bits.
    localparam int SHIFT_OP_W = 2;

    typedef logic [ALU_CTRL_W-1:0] alu_ctrl_t;          // selects one ALU operation.
    typedef logic [SHAMT_W-1:0]    shamt_t;             // shift amount, taken from b[4:0].
    typedef logic [SHIFT_OP_W-1:0] shift_op_t;          // shift kind handed to the shifter.

    // Arithmetic and logic operations.
    localparam alu_ctrl_t ALU_ADD   = 5'd0;
    localparam alu_ctrl_t ALU_SUB   = 5'd1;
    localparam alu_ctrl_t ALU_XOR   = 5'd2;
    localparam alu_ctrl_t ALU_OR    = 5'd3;
    localparam alu_ctrl_t ALU_AND   = 5'd4;

    // Shifts.
    localparam alu_ctrl_t ALU_SLL   = 5'd5;
    localparam alu_ctrl_t ALU_SRL   = 5'd6;
    localparam alu_ctrl_t ALU_SRA   = 5'd7;

    // Set-less-than and the upper-immediate forms.
    localparam alu_ctrl_t ALU_SLT   = 5'd8;
    localparam alu_ctrl_t ALU_SLTU  = 5'd9;
    localparam alu_ctrl_t ALU_LUI   = 5'd10;            // passes b through unchanged.
    localparam alu_ctrl_t ALU_AUIPC = 5'd11;            // a holds the pc, b the shifted immediate.

    // Branch compares give their truth value in bit 0.
    localparam alu_ctrl_t ALU_BEQ   = 5'd12;
    localparam alu_ctrl_t ALU_BNE   = 5'd13;
    localparam alu_ctrl_t ALU_BLT   = 5'd14;
    localparam alu_ctrl_t ALU_BGE   = 5'd15;
    localparam alu_ctrl_t ALU_BLTU  = 5'd16;
    localparam alu_ctrl_t ALU_BGEU  = 5'd17;

    // Shift kinds.
    localparam shift_op_t SH_SLL = 2'd0;
    localparam shift_op_t SH_SRL = 2'd1;
    localparam shift_op_t SH_SRA = 2'd2;                // right shift with sign fill.

endpackage

`default_nettype wire

// ==== hdl/riscv_pkg.sv ====
// RV32I instruction-field types with the opcode and funct3 encodings used by the execute stage.
`default_nettype none

package riscv_pkg;

    localparam int XLEN = 32;                           // data path width of the core.

    typedef logic [XLEN-1:0] word_t;                    // one register-sized data word.
    typedef logic [6:0]      opcode_t;                  // major opcode, instruction bits 6:0.
    typedef logic [2:0]      funct3_t;                  // minor function, instruction bits 14:12.

    // Major opcodes that reach the execute stage.
    localparam opcode_t OP     = 7'b0110011;            // register-register arithmetic.
    localparam opcode_t OP_IMM = 7'b0010011;            // register-immediate arithmetic.
    localparam opcode_t BRANCH = 7'b1100011;
    localparam opcode_t LOAD   = 7'b0000011;
    localparam opcode_t STORE  = 7'b0100011;
    localparam opcode_t LUI    = 7'b0110111;
    localparam opcode_t AUIPC  = 7'b0010111;

    // funct3 values of the OP and OP_IMM groups.
    localparam funct3_t F3_ADD_SUB = 3'b000;            // funct7 bit 5 picks SUB on OP.
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;            // funct7 bit 5 picks SRA.
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct3 values of the BRANCH group.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire
